//--- Bender.yml
package:
  name: proc

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/isa_pkg.sv
      - common/core_pkg.sv
      - common/rf_if.sv
      - design/sram_1r1w.sv
      - design/regfile.sv
      - core/fetch_stage.sv
      - core/decode_stage.sv
      - core/exec_mem_stage.sv
      - design/proc.sv
  - target: test
    include_dirs:
      - common
    files:
      - verification/tb_clock_gen.sv
      - verification/tb_proc.sv

//--- build.f
+incdir+common
common/isa_pkg.sv
common/core_pkg.sv
common/rf_if.sv
design/sram_1r1w.sv
design/regfile.sv
core/fetch_stage.sv
core/decode_stage.sv
core/exec_mem_stage.sv
design/proc.sv
verification/tb_clock_gen.sv
verification/tb_proc.sv

//--- common/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data path and instruction word width
`define CORE_WORD_WIDTH 16

// General purpose registers
`define CORE_REG_COUNT 8

// Memory depths in words
`define CORE_IMEM_DEPTH 256
`define CORE_DMEM_DEPTH 256

`endif

//--- common/core_pkg.sv
package core_pkg;

   import isa_pkg::*;

   // Write-back source
   typedef enum logic [1:0] {
      WB_ALU,
      WB_MEM,
      WB_IMM
   } wb_src_e;

   // Decoded control for one instruction
   typedef struct packed {
      alu_op_e alu_op;
      logic    b_is_imm;
      logic    mem_rd;
      logic    mem_wr;
      logic    reg_wr;
      wb_src_e wb_src;
      logic    branch;
      logic    halt;
      logic    illegal;
   } ctrl_t;

   // Fetch to decode
   typedef struct packed {
      word_t  pc_plus2;
      instr_t instr;
   } fetch_out_t;

   // Decode to execute/memory, pc_plus2 rides along for branches
   typedef struct packed {
      ctrl_t    ctrl;
      word_t    pc_plus2;
      word_t    rs_val;
      word_t    rt_val;
      word_t    imm;
      reg_idx_t dest;
   } decode_out_t;

endpackage

//--- common/isa_pkg.sv
`include "core_config.svh"

package isa_pkg;

   // Machine word and register index
   typedef logic [`CORE_WORD_WIDTH-1:0] word_t;
   typedef logic [$clog2(`CORE_REG_COUNT)-1:0] reg_idx_t;

   // Major opcodes, anything else is illegal
   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001,
      OP_BEQZ  = 5'b01100,
      OP_ST    = 5'b10000,
      OP_LD    = 5'b10001,
      OP_LBI   = 5'b11000,
      OP_RTYPE = 5'b11011
   } opcode_e;

   // Field layout, imm5 is [4:0] and imm8 is [7:0]
   typedef struct packed {
      opcode_e    opcode;
      reg_idx_t   rs;
      reg_idx_t   rt;
      reg_idx_t   rd;
      logic [1:0] funct;
   } instr_t;

   // ALU ops, same encoding as the R-type funct field
   typedef enum logic [1:0] {
      ALU_ADD = 2'b00,
      ALU_SUB = 2'b01,
      ALU_XOR = 2'b10,
      ALU_AND = 2'b11
   } alu_op_e;

   // Bubble shown while halted or held in reset
   localparam instr_t NOP_INSTR = '{opcode: OP_NOP, default: '0};

   // Sign-extended immediates
   function automatic word_t sext_imm5(instr_t i);
      return word_t'(signed'({i.rd, i.funct}));
   endfunction

   function automatic word_t sext_imm8(instr_t i);
      return word_t'(signed'({i.rt, i.rd, i.funct}));
   endfunction

endpackage

//--- common/rf_if.sv
interface rf_if;

   import isa_pkg::*;

   // Read selects and data
   reg_idx_t rs1;
   reg_idx_t rs2;
   word_t    rd1;
   word_t    rd2;

   // Write port
   logic     we;
   reg_idx_t ws;
   word_t    wd;

   // Decode side drives selects, gets data back
   modport stage_rd (output rs1, rs2, input rd1, rd2);

   // Execute side drives the write port
   modport stage_wr (output we, ws, wd);

   modport regfile (input rs1, rs2, we, ws, wd, output rd1, rd2);

endinterface

//--- core/decode_stage.sv
module decode_stage (
   input  core_pkg::fetch_out_t  fin,
   rf_if.stage_rd                rf,
   output core_pkg::decode_out_t dout
);

   import isa_pkg::*;
   import core_pkg::*;

   instr_t   instr;
   ctrl_t    ctrl;
   reg_idx_t dest;
   logic     use_imm8;

   assign instr = fin.instr;

   // Register reads, rs on port 1 and rt on port 2
   assign rf.rs1 = instr.rs;
   assign rf.rs2 = instr.rt;

   // Opcode to control
   always_comb begin
      ctrl     = '0;
      dest     = instr.rt;
      use_imm8 = 1'b0;
      case (instr.opcode)
         OP_HALT: ctrl.halt = 1'b1;
         OP_NOP: ;
         OP_ADDI, OP_SUBI: begin
            ctrl.alu_op   = (instr.opcode == OP_SUBI) ? ALU_SUB : ALU_ADD;
            ctrl.b_is_imm = 1'b1;
            ctrl.reg_wr   = 1'b1;
            ctrl.wb_src   = WB_ALU;
         end
         OP_BEQZ: begin
            ctrl.branch = 1'b1;
            use_imm8    = 1'b1;
         end
         // Store data is rt, address is rs + imm5
         OP_ST: ctrl.mem_wr = 1'b1;
         OP_LD: begin
            ctrl.mem_rd = 1'b1;
            ctrl.reg_wr = 1'b1;
            ctrl.wb_src = WB_MEM;
         end
         // LBI writes back into rs
         OP_LBI: begin
            ctrl.reg_wr = 1'b1;
            ctrl.wb_src = WB_IMM;
            dest        = instr.rs;
            use_imm8    = 1'b1;
         end
         OP_RTYPE: begin
            ctrl.alu_op = alu_op_e'(instr.funct);
            ctrl.reg_wr = 1'b1;
            ctrl.wb_src = WB_ALU;
            dest        = instr.rd;
         end
         // Unknown opcode, all enables stay low
         default: ctrl.illegal = 1'b1;
      endcase
   end

   assign dout.ctrl     = ctrl;
   assign dout.pc_plus2 = fin.pc_plus2;
   assign dout.rs_val   = rf.rd1;
   assign dout.rt_val   = rf.rd2;
   assign dout.imm      = use_imm8 ? sext_imm8(instr) : sext_imm5(instr);
   assign dout.dest     = dest;

endmodule

//--- core/exec_mem_stage.sv
`include "core_config.svh"

module exec_mem_stage (
   input  logic                  clk,
   input  logic                  rst_n,
   input  core_pkg::decode_out_t din,
   rf_if.stage_wr                rf,
   output logic                  br_taken,
   output isa_pkg::word_t        br_target,
   output logic                  halt_req,
   output logic                  err
);

   import isa_pkg::*;
   import core_pkg::*;

   localparam int DMEM_AW = $clog2(`CORE_DMEM_DEPTH);

   word_t alu_b;
   word_t alu_y;
   word_t mem_addr;
   word_t dmem_rdata;
   word_t load_data;

   // Second operand from rt or the immediate
   assign alu_b = din.ctrl.b_is_imm ? din.imm : din.rt_val;

   // SUB is rs minus operand
   always_comb begin
      case (din.ctrl.alu_op)
         ALU_ADD: alu_y = din.rs_val + alu_b;
         ALU_SUB: alu_y = din.rs_val - alu_b;
         ALU_XOR: alu_y = din.rs_val ^ alu_b;
         ALU_AND: alu_y = din.rs_val & alu_b;
         default: alu_y = '0;
      endcase
   end

   // Base plus offset, word index from bits [8:1]
   assign mem_addr = din.rs_val + din.imm;

   sram_1r1w #(
      .payload_t (word_t),
      .DEPTH     (`CORE_DMEM_DEPTH)
   ) dmem0 (
      .clk   (clk),
      .wr    (din.ctrl.mem_wr),
      .waddr (mem_addr[DMEM_AW:1]),
      .wdata (din.rt_val),
      .raddr (mem_addr[DMEM_AW:1]),
      .rdata (dmem_rdata)
   );

   // Only loads pass memory data on
   assign load_data = din.ctrl.mem_rd ? dmem_rdata : '0;

   // Write-back select
   assign rf.we = din.ctrl.reg_wr;
   assign rf.ws = din.dest;
   always_comb begin
      case (din.ctrl.wb_src)
         WB_MEM:  rf.wd = load_data;
         WB_IMM:  rf.wd = din.imm;
         default: rf.wd = alu_y;
      endcase
   end

   // BEQZ, target is pc+2 plus imm8 doubled
   assign br_taken  = din.ctrl.branch && (din.rs_val == '0);
   assign br_target = din.pc_plus2 + {din.imm[`CORE_WORD_WIDTH-2:0], 1'b0};

   assign halt_req = din.ctrl.halt;

   // Sticky until reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         err <= 1'b0;
      end else if (din.ctrl.illegal) begin
         err <= 1'b1;
      end
   end

endmodule

//--- core/fetch_stage.sv
`include "core_config.svh"

module fetch_stage (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  imem_wr,
   input  logic [$clog2(`CORE_IMEM_DEPTH)-1:0]   imem_addr,
   input  isa_pkg::word_t                        imem_data,
   input  logic                                  br_taken,
   input  isa_pkg::word_t                        br_target,
   input  logic                                  halt_req,
   output logic                                  halted,
   output core_pkg::fetch_out_t                  fout
);

   import isa_pkg::*;
   import core_pkg::*;

   localparam int IMEM_AW = $clog2(`CORE_IMEM_DEPTH);

   word_t  pc;
   word_t  pc_plus2;
   word_t  next_pc;
   instr_t imem_rdata;

   // Program memory, word indexed by pc[8:1]
   sram_1r1w #(
      .payload_t (instr_t),
      .DEPTH     (`CORE_IMEM_DEPTH)
   ) imem0 (
      .clk   (clk),
      .wr    (imem_wr),
      .waddr (imem_addr),
      .wdata (instr_t'(imem_data)),
      .raddr (pc[IMEM_AW:1]),
      .rdata (imem_rdata)
   );

   assign pc_plus2 = pc + word_t'(2);

   // Hold on halt, else branch or step
   always_comb begin
      if (halted || halt_req) begin
         next_pc = pc;
      end else if (br_taken) begin
         next_pc = br_target;
      end else begin
         next_pc = pc_plus2;
      end
   end

   // PC and sticky halt flag
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc     <= '0;
         halted <= 1'b0;
      end else begin
         pc     <= next_pc;
         halted <= halted | halt_req;
      end
   end

   // Bubble while in reset or halted so nothing downstream acts
   assign fout.pc_plus2 = pc_plus2;
   assign fout.instr    = (rst_n && !halted) ? imem_rdata : NOP_INSTR;

endmodule

//--- design/proc.sv
`include "core_config.svh"

module proc (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                imem_wr,
   input  logic [$clog2(`CORE_IMEM_DEPTH)-1:0] imem_addr,
   input  isa_pkg::word_t                      imem_data,
   output logic                                retire_valid,
   output isa_pkg::reg_idx_t                   retire_reg,
   output isa_pkg::word_t                      retire_data,
   output logic                                halted,
   output logic                                err
);

   import isa_pkg::*;
   import core_pkg::*;

   fetch_out_t  fout;
   decode_out_t dout;
   logic        br_taken;
   word_t       br_target;
   logic        halt_req;

   rf_if rf_bus ();

   regfile rf0 (
      .clk   (clk),
      .rst_n (rst_n),
      .rf    (rf_bus.regfile)
   );

   fetch_stage fetch0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .imem_wr   (imem_wr),
      .imem_addr (imem_addr),
      .imem_data (imem_data),
      .br_taken  (br_taken),
      .br_target (br_target),
      .halt_req  (halt_req),
      .halted    (halted),
      .fout      (fout)
   );

   decode_stage decode0 (
      .fin  (fout),
      .rf   (rf_bus.stage_rd),
      .dout (dout)
   );

   exec_mem_stage exec0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .din       (dout),
      .rf        (rf_bus.stage_wr),
      .br_taken  (br_taken),
      .br_target (br_target),
      .halt_req  (halt_req),
      .err       (err)
   );

   // Retire port mirrors the register write
   assign retire_valid = rf_bus.we;
   assign retire_reg   = rf_bus.ws;
   assign retire_data  = rf_bus.wd;

endmodule

//--- design/regfile.sv
`include "core_config.svh"

module regfile (
   input logic   clk,
   input logic   rst_n,
   rf_if.regfile rf
);

   import isa_pkg::*;

   word_t regs [`CORE_REG_COUNT];

   // All registers clear on reset, one write per edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `CORE_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (rf.we) begin
         regs[rf.ws] <= rf.wd;
      end
   end

   // Write-to-read bypass on both ports
   assign rf.rd1 = (rf.we && (rf.ws == rf.rs1)) ? rf.wd : regs[rf.rs1];
   assign rf.rd2 = (rf.we && (rf.ws == rf.rs2)) ? rf.wd : regs[rf.rs2];

endmodule

//--- design/sram_1r1w.sv
module sram_1r1w #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 256
) (
   input  logic                     clk,
   input  logic                     wr,
   input  logic [$clog2(DEPTH)-1:0] waddr,
   input  payload_t                 wdata,
   input  logic [$clog2(DEPTH)-1:0] raddr,
   output payload_t                 rdata
);

   // Storage array, contents undefined until written
   payload_t mem [DEPTH];

   // Write on the rising edge
   always_ff @(posedge clk) begin
      if (wr) begin
         mem[waddr] <= wdata;
      end
   end

   // Asynchronous read
   assign rdata = mem[raddr];

endmodule

//--- verification/tb_clock_gen.sv
module tb_clock_gen (
   output logic clk,
   output logic rst_n
);

   timeunit 1ns;
   timeprecision 100ps;

   // 20 ns period, reset low from time zero
   initial begin
      clk   = 1'b0;
      rst_n = 1'b0;
      forever #10 clk = ~clk;
   end

   // Pull reset low just after an edge
   task automatic assert_reset();
      @(posedge clk);
      #2 rst_n = 1'b0;
   endtask

   // Four more cycles in reset, then release off the edge
   task automatic release_reset();
      repeat (4) @(posedge clk);
      #2 rst_n = 1'b1;
   endtask

endmodule

//--- verification/tb_proc.sv
`include "core_config.svh"

module tb_proc;

   timeunit 1ns;
   timeprecision 100ps;

   import isa_pkg::*;

   localparam int RUN_LIMIT = 200;

   // One register write seen on the retire port
   typedef struct packed {
      reg_idx_t r;
      word_t    d;
   } retire_t;

   logic                                clk;
   logic                                rst_n;
   logic                                imem_wr;
   logic [$clog2(`CORE_IMEM_DEPTH)-1:0] imem_addr;
   word_t                               imem_data;
   logic                                retire_valid;
   reg_idx_t                            retire_reg;
   word_t                               retire_data;
   logic                                halted;
   logic                                err;

   word_t   prog [$];
   retire_t exp_q [$];
   retire_t got_q [$];
   word_t   lfsr_state = 16'd33;
   int      errors = 0;

   tb_clock_gen clk_gen0 (
      .clk   (clk),
      .rst_n (rst_n)
   );

   proc dut0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .imem_wr      (imem_wr),
      .imem_addr    (imem_addr),
      .imem_data    (imem_data),
      .retire_valid (retire_valid),
      .retire_reg   (retire_reg),
      .retire_data  (retire_data),
      .halted       (halted),
      .err          (err)
   );

   // Galois LFSR, taps 16,14,13,11
   function automatic word_t next_lfsr(word_t s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // One LFSR step per bit
   function automatic logic [7:0] rand_byte();
      logic [7:0] b;
      b = '0;
      for (int i = 0; i < 8; i++) begin
         lfsr_state = next_lfsr(lfsr_state);
         b = {b[6:0], lfsr_state[0]};
      end
      return b;
   endfunction

   function automatic word_t sx8(logic [7:0] v);
      return {{8{v[7]}}, v};
   endfunction

   function automatic word_t sx5(logic [4:0] v);
      return {{11{v[4]}}, v};
   endfunction

   // Encoders for the three instruction shapes
   function automatic word_t enc_i8(opcode_e op, reg_idx_t rs, logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic word_t enc_i5(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic word_t enc_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, alu_op_e f);
      return {OP_RTYPE, rs, rt, rd, f};
   endfunction

   task automatic add_instr(word_t w);
      prog.push_back(w);
   endtask

   task automatic expect_retire(reg_idx_t r, word_t d);
      retire_t ev;
      ev.r = r;
      ev.d = d;
      exp_q.push_back(ev);
   endtask

   task automatic check_retire(int n, reg_idx_t exp_r, word_t exp_d, reg_idx_t act_r,
                               word_t act_d);
      if (act_r !== exp_r) begin
         $display("ERROR retire_reg[%0d]: expected %h, got %h", n, exp_r, act_r);
         errors++;
      end
      if (act_d !== exp_d) begin
         $display("ERROR retire_data[%0d]: expected %h, got %h", n, exp_d, act_d);
         errors++;
      end
   endtask

   task automatic check_flag(string name, logic exp_v, logic act_v);
      if (act_v !== exp_v) begin
         $display("ERROR %s: expected %h, got %h", name, exp_v, act_v);
         errors++;
      end
   endtask

   // Reload under reset, run until halted, gather retires
   task automatic run_program();
      int      cycles;
      retire_t ev;
      got_q.delete();
      clk_gen0.assert_reset();
      foreach (prog[i]) begin
         @(posedge clk);
         #2;
         imem_wr   = 1'b1;
         imem_addr = i;
         imem_data = prog[i];
      end
      @(posedge clk);
      #2 imem_wr = 1'b0;
      clk_gen0.release_reset();
      cycles = 0;
      // Mid-cycle sampling, outputs settled
      while (!halted && cycles < RUN_LIMIT) begin
         @(negedge clk);
         if (retire_valid) begin
            ev.r = retire_reg;
            ev.d = retire_data;
            got_q.push_back(ev);
         end
         cycles++;
      end
      if (!halted) begin
         $display("Timeout: the core did not halt within %0d cycles", RUN_LIMIT);
         errors++;
      end
   endtask

   task automatic compare_retires(string test_name);
      int n;
      if (got_q.size() != exp_q.size()) begin
         $display("%s: expected %0d register writes but saw %0d", test_name, exp_q.size(),
                  got_q.size());
         errors++;
      end
      n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
      for (int i = 0; i < n; i++) begin
         check_retire(i, exp_q[i].r, exp_q[i].d, got_q[i].r, got_q[i].d);
      end
      prog.delete();
      exp_q.delete();
   endtask

   // Further cycles after halt, counts stray retires
   task automatic watch_idle(int n, output int count);
      count = 0;
      repeat (n) begin
         @(negedge clk);
         if (retire_valid) begin
            count++;
         end
      end
   endtask

   // Immediates, negative ones too
   task automatic test_imm();
      add_instr(enc_i8(OP_LBI, 3'd1, 8'hFD));
      add_instr(enc_i8(OP_LBI, 3'd2, 8'h45));
      add_instr(enc_i5(OP_ADDI, 3'd1, 3'd3, 5'd7));
      add_instr(enc_i5(OP_SUBI, 3'd2, 3'd4, 5'b11110));
      add_instr(enc_i5(OP_ADDI, 3'd2, 3'd5, 5'b10000));
      add_instr({OP_HALT, 11'd0});
      expect_retire(3'd1, sx8(8'hFD));
      expect_retire(3'd2, sx8(8'h45));
      expect_retire(3'd3, sx8(8'hFD) + sx5(5'd7));
      expect_retire(3'd4, sx8(8'h45) - sx5(5'b11110));
      expect_retire(3'd5, sx8(8'h45) + sx5(5'b10000));
      run_program();
      compare_retires("imm");
   endtask

   // R-type on random bytes, XOR reads r4 right after it is written
   task automatic test_alu();
      logic [7:0] a;
      logic [7:0] b;
      word_t      s;
      word_t      d;
      word_t      x;
      for (int round = 0; round < 3; round++) begin
         a = rand_byte();
         b = rand_byte();
         s = sx8(a) + sx8(b);
         d = sx8(a) - sx8(b);
         x = s ^ d;
         add_instr(enc_i8(OP_LBI, 3'd1, a));
         add_instr(enc_i8(OP_LBI, 3'd2, b));
         add_instr(enc_r(3'd1, 3'd2, 3'd3, ALU_ADD));
         add_instr(enc_r(3'd1, 3'd2, 3'd4, ALU_SUB));
         add_instr(enc_r(3'd3, 3'd4, 3'd5, ALU_XOR));
         add_instr(enc_r(3'd5, 3'd1, 3'd6, ALU_AND));
         add_instr({OP_HALT, 11'd0});
         expect_retire(3'd1, sx8(a));
         expect_retire(3'd2, sx8(b));
         expect_retire(3'd3, s);
         expect_retire(3'd4, d);
         expect_retire(3'd5, x);
         expect_retire(3'd6, x & sx8(a));
         run_program();
         compare_retires("alu");
      end
   endtask

   // Two stores off one base, loaded back in order
   task automatic test_mem();
      add_instr(enc_i8(OP_LBI, 3'd1, 8'h20));
      add_instr(enc_i8(OP_LBI, 3'd2, 8'h5A));
      add_instr(enc_i8(OP_LBI, 3'd3, 8'h9C));
      add_instr(enc_i5(OP_ST, 3'd1, 3'd2, 5'd4));
      add_instr(enc_i5(OP_ST, 3'd1, 3'd3, 5'b11010));
      add_instr(enc_i5(OP_LD, 3'd1, 3'd4, 5'd4));
      add_instr(enc_i5(OP_LD, 3'd1, 3'd5, 5'b11010));
      add_instr({OP_HALT, 11'd0});
      expect_retire(3'd1, 16'h0020);
      expect_retire(3'd2, 16'h005A);
      expect_retire(3'd3, 16'hFF9C);
      expect_retire(3'd4, 16'h005A);
      expect_retire(3'd5, 16'hFF9C);
      run_program();
      compare_retires("mem");
   endtask

   // Taken skips index 3, not taken falls into index 5
   task automatic test_branch();
      add_instr(enc_i8(OP_LBI, 3'd1, 8'h00));
      add_instr(enc_i8(OP_LBI, 3'd2, 8'h09));
      add_instr(enc_i8(OP_BEQZ, 3'd1, 8'h01));
      add_instr(enc_i8(OP_LBI, 3'd3, 8'h11));
      add_instr(enc_i8(OP_BEQZ, 3'd2, 8'h01));
      add_instr(enc_i8(OP_LBI, 3'd4, 8'h22));
      add_instr({OP_HALT, 11'd0});
      expect_retire(3'd1, 16'h0000);
      expect_retire(3'd2, 16'h0009);
      expect_retire(3'd4, 16'h0022);
      run_program();
      compare_retires("branch");
   endtask

   task automatic test_halt();
      int stray;
      add_instr(enc_i8(OP_LBI, 3'd1, 8'h05));
      add_instr({OP_HALT, 11'd0});
      add_instr(enc_i8(OP_LBI, 3'd2, 8'h06));
      expect_retire(3'd1, 16'h0005);
      run_program();
      compare_retires("halt");
      watch_idle(20, stray);
      if (stray != 0) begin
         $display("halt: %0d register writes after the core halted", stray);
         errors++;
      end
      check_flag("halted", 1'b1, halted);
      check_flag("err", 1'b0, err);
   endtask

   // Opcode 00111 is unassigned
   task automatic test_illegal();
      int stray;
      add_instr(enc_i8(OP_LBI, 3'd1, 8'h7F));
      add_instr({5'b00111, 11'd0});
      add_instr(enc_i8(OP_LBI, 3'd2, 8'h80));
      add_instr({OP_HALT, 11'd0});
      expect_retire(3'd1, 16'h007F);
      expect_retire(3'd2, 16'hFF80);
      run_program();
      compare_retires("illegal");
      check_flag("err", 1'b1, err);
      // Sticky through idle cycles
      watch_idle(20, stray);
      if (stray != 0) begin
         $display("illegal: %0d register writes after the core halted", stray);
         errors++;
      end
      check_flag("err", 1'b1, err);
   endtask

   initial begin
      imem_wr   = 1'b0;
      imem_addr = '0;
      imem_data = '0;
      test_imm();
      test_alu();
      test_mem();
      test_branch();
      test_halt();
      test_illegal();
      $display("Tests done with %0d errors", errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
